// ==== build.f ====
source/dma_pkg.sv
source/mem_bus_if.sv
source/dma_controller.sv
source/bus_arbiter.sv
source/block_memory.sv
source/dma_subsystem.sv
sim/tb_dma_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the DMA subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found on PATH"
	exit 1
fi

verilator --binary --timing --top-module tb_dma_subsystem -f build.f -o sim_dma
if [ $? -ne 0 ]; then
	echo "compile step did not succeed"
	exit 1
fi

sim_out=$(./obj_dir/sim_dma)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status"
	exit 1
fi

# pass only when the testbench printed its pass line
if grep -q "All tests passed" <<< "$sim_out"; then
	exit 0
fi
exit 1

// ==== sim/tb_dma_subsystem.sv ====
module tb_dma_subsystem import dma_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int clk_period = 20;
	// wait limits in cycles for a single transfer and a single CPU read
	localparam int xfer_limit = 200;
	localparam int rd_limit = 100;
	// about 4 cycles per read and per block plus 8 per transfer
	localparam int est_cycles = 220 * 4 + 60 * 4 + 12 * 8 + 100;
	// twice the estimated run length
	localparam int watchdog_ns = 2 * est_cycles * clk_period;

	logic clk = 1'b0;
	logic rst;
	logic cmd_valid;
	word_t cmd_address;
	word_t cmd_length;
	logic dev_valid;
	word_t dev_offset;
	block_t dev_data;
	logic interrupt;
	logic cpu_rd_strobe;
	word_t cpu_rd_addr;
	logic cpu_rd_done;
	word_t cpu_rd_data;

	// tag placed in the upper byte of every device word
	logic [7:0] cur_tag = 8'h00;
	// strobe counters kept by the monitor and read at the rising edge
	int irq_count = 0;
	int dev_count = 0;
	int rd_count = 0;
	word_t rd_word;
	word_t offsets[$];
	int err_count = 0;
	int check_count = 0;
	int tests_run = 0;
	int seed = 32'h43d1b804;

	dma_subsystem i_dut (
		.clk           (clk),
		.rst           (rst),
		.cmd_valid     (cmd_valid),
		.cmd_address   (cmd_address),
		.cmd_length    (cmd_length),
		.dev_valid     (dev_valid),
		.dev_offset    (dev_offset),
		.dev_data      (dev_data),
		.interrupt     (interrupt),
		.cpu_rd_strobe (cpu_rd_strobe),
		.cpu_rd_addr   (cpu_rd_addr),
		.cpu_rd_done   (cpu_rd_done),
		.cpu_rd_data   (cpu_rd_data)
	);

	always #(clk_period / 2) clk = ~clk;

	// word idx of a transfer carries the tag in the upper byte and idx in the lower
	function automatic word_t pattern_word(input logic [7:0] tag, input int idx);
		return {tag, 8'(idx)};
	endfunction

	// device model and monitor run on the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (dev_valid) begin
				for (int j = 0; j < BLOCK_WORDS; j++)
					dev_data[j] = pattern_word(cur_tag, int'(dev_offset) * 4 + j);
				offsets.push_back(dev_offset);
				dev_count++;
			end
			if (interrupt)
				irq_count++;
			if (cpu_rd_done) begin
				rd_word = cpu_rd_data;
				rd_count++;
			end
		end
	end

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			err_count++;
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			err_count++;
		end
	endtask

	function automatic void finish_test(input string name, input int first_err);
		tests_run++;
		if (err_count == first_err)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, err_count - first_err);
	endfunction

	task automatic send_cmd(input word_t addr, input word_t len, input logic [7:0] tag);
		cur_tag = tag;
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd_address = addr;
		cmd_length = len;
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	task automatic wait_irq(input int start);
		int n;
		n = 0;
		while (irq_count == start && n < xfer_limit) begin
			@(posedge clk);
			n++;
		end
		if (irq_count == start) begin
			$display("no interrupt arrived within %0d cycles", xfer_limit);
			err_count++;
		end
	endtask

	task automatic wait_dev_pulse(input int start);
		int n;
		n = 0;
		while (dev_count == start && n < xfer_limit) begin
			@(posedge clk);
			n++;
		end
		if (dev_count == start) begin
			$display("no device strobe arrived within %0d cycles", xfer_limit);
			err_count++;
		end
	endtask

	task automatic run_transfer(input word_t addr, input word_t len, input logic [7:0] tag);
		int start;
		start = irq_count;
		send_cmd(addr, len, tag);
		wait_irq(start);
	endtask

	// one strobe and then a wait for the done strobe
	task automatic cpu_read(input word_t addr, output word_t data);
		int start;
		int n;
		start = rd_count;
		@(negedge clk);
		cpu_rd_strobe = 1'b1;
		cpu_rd_addr = addr;
		@(negedge clk);
		cpu_rd_strobe = 1'b0;
		n = 0;
		while (rd_count == start && n < rd_limit) begin
			@(posedge clk);
			n++;
		end
		if (rd_count == start) begin
			$display("no read done for address %h within %0d cycles", addr, rd_limit);
			err_count++;
		end
		data = rd_word;
	endtask

	// reads back every word of a transfer with the address wrapping
	task automatic check_region(input word_t addr, input word_t len, input logic [7:0] tag);
		word_t got;
		for (int i = 0; i < int'(len); i++) begin
			cpu_read(addr + word_t'(i), got);
			compare_word("cpu_rd_data", got, pattern_word(tag, i));
		end
	endtask

	task automatic reset_idle();
		int first_err;
		first_err = err_count;
		repeat (6) begin
			@(negedge clk);
			compare_flag("interrupt", interrupt, 1'b0);
			compare_flag("dev_valid", dev_valid, 1'b0);
			compare_flag("cpu_rd_done", cpu_rd_done, 1'b0);
		end
		finish_test("reset idle", first_err);
	endtask

	task automatic full_transfer();
		int first_err;
		int irq_start;
		first_err = err_count;
		irq_start = irq_count;
		offsets.delete();
		run_transfer(16'h0020, 16'd16, 8'h02);
		repeat (6) @(posedge clk);
		compare_word("interrupt pulses", word_t'(irq_count - irq_start), 16'd1);
		compare_word("dev_valid pulses", word_t'(offsets.size()), 16'd4);
		foreach (offsets[k])
			compare_word("dev_offset", offsets[k], word_t'(k));
		check_region(16'h0020, 16'd16, 8'h02);
		finish_test("transfer of 16 words", first_err);
	endtask

	// the read is held by the arbiter until the DMA lets go of the bus
	task automatic read_during_transfer();
		int first_err;
		int irq_start;
		int rd_start;
		word_t got;
		first_err = err_count;
		irq_start = irq_count;
		rd_start = rd_count;
		send_cmd(16'h0020, 16'd16, 8'h03);
		wait_dev_pulse(dev_count);
		cpu_read(16'h002c, got);
		compare_word("cpu_rd_data", got, pattern_word(8'h03, 12));
		wait_irq(irq_start);
		repeat (6) @(posedge clk);
		compare_word("interrupt pulses", word_t'(irq_count - irq_start), 16'd1);
		compare_word("cpu_rd_done pulses", word_t'(rd_count - rd_start), 16'd1);
		check_region(16'h0020, 16'd16, 8'h03);
		finish_test("read during transfer", first_err);
	endtask

	task automatic short_lengths();
		int first_err;
		int dev_start;
		int irq_start;
		word_t got;
		first_err = err_count;
		// two blocks first so the word after the short one is known
		run_transfer(16'h0040, 16'd8, 8'h41);
		dev_start = dev_count;
		run_transfer(16'h0040, 16'd6, 8'h04);
		compare_word("dev_valid pulses", word_t'(dev_count - dev_start), 16'd1);
		check_region(16'h0040, 16'd4, 8'h04);
		cpu_read(16'h0044, got);
		compare_word("cpu_rd_data", got, pattern_word(8'h41, 4));
		dev_start = dev_count;
		irq_start = irq_count;
		run_transfer(16'h0080, 16'd0, 8'h42);
		repeat (6) @(posedge clk);
		compare_word("dev_valid pulses", word_t'(dev_count - dev_start), 16'd0);
		compare_word("interrupt pulses", word_t'(irq_count - irq_start), 16'd1);
		finish_test("short lengths", first_err);
	endtask

	task automatic busy_command();
		int first_err;
		int irq_start;
		int dev_start;
		first_err = err_count;
		run_transfer(16'h00a0, 16'd4, 8'h50);
		irq_start = irq_count;
		dev_start = dev_count;
		send_cmd(16'h0060, 16'd16, 8'h05);
		wait_dev_pulse(dev_start);
		// lands while the engine is busy
		send_cmd(16'h00a0, 16'd8, 8'h05);
		wait_irq(irq_start);
		repeat (20) @(posedge clk);
		compare_word("interrupt pulses", word_t'(irq_count - irq_start), 16'd1);
		compare_word("dev_valid pulses", word_t'(dev_count - dev_start), 16'd4);
		check_region(16'h00a0, 16'd4, 8'h50);
		check_region(16'h0060, 16'd16, 8'h05);
		finish_test("command while busy", first_err);
	endtask

	// full 16-bit addresses of which the memory keeps only the low byte
	task automatic random_transfers();
		int first_err;
		word_t addr;
		word_t len;
		first_err = err_count;
		for (int t = 0; t < 5; t++) begin
			addr = word_t'($random(seed));
			// first block straddles the top of the memory
			if (t == 0)
				addr[MEM_ADDR_W-1:0] = mem_addr_t'(MEM_DEPTH - 2);
			len = word_t'((($random(seed) & 7) + 1) * 4);
			run_transfer(addr, len, 8'h60 + 8'(t));
			check_region(addr, len, 8'h60 + 8'(t));
		end
		finish_test("random transfers", first_err);
	endtask

	initial begin
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd_address = '0;
		cmd_length = '0;
		cpu_rd_strobe = 1'b0;
		cpu_rd_addr = '0;
		dev_data = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		reset_idle();
		full_transfer();
		read_during_transfer();
		short_lengths();
		busy_command();
		random_transfers();
		$display("%0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
		if (err_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns", watchdog_ns);
		$display("Some tests failed");
		$finish;
	end

endmodule

// ==== source/dma_subsystem.sv ====
module dma_subsystem import dma_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	// CPU command
	input  logic   cmd_valid,
	input  word_t  cmd_address,
	input  word_t  cmd_length,
	// external device
	output logic   dev_valid,
	output word_t  dev_offset,
	input  block_t dev_data,
	// transfer done
	output logic   interrupt,
	// CPU read port into the memory
	input  logic   cpu_rd_strobe,
	input  word_t  cpu_rd_addr,
	output logic   cpu_rd_done,
	output word_t  cpu_rd_data
);

	// bus ownership between controller and arbiter
	logic bus_request;
	logic bus_grant;

	// controller to arbiter
	mem_bus_if dma_bus ();
	// arbiter to memory
	mem_bus_if mem_bus ();

	dma_controller i_controller (
		.clk         (clk),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd_address (cmd_address),
		.cmd_length  (cmd_length),
		.bus_request (bus_request),
		.bus_grant   (bus_grant),
		.dev_valid   (dev_valid),
		.dev_offset  (dev_offset),
		.dev_data    (dev_data),
		.interrupt   (interrupt),
		.bus         (dma_bus.master)
	);

	bus_arbiter i_arbiter (
		.clk           (clk),
		.rst           (rst),
		.bus_request   (bus_request),
		.bus_grant     (bus_grant),
		.cpu_rd_strobe (cpu_rd_strobe),
		.cpu_rd_addr   (cpu_rd_addr),
		.cpu_rd_done   (cpu_rd_done),
		.cpu_rd_data   (cpu_rd_data),
		.dma_side      (dma_bus.arbiter),
		.mem_side      (mem_bus.arbiter_out)
	);

	// word memory with a fixed ack delay
	block_memory i_memory (
		.clk (clk),
		.bus (mem_bus.memory)
	);

endmodule

// ==== source/block_memory.sv ====
module block_memory import dma_pkg::*; (
	input  logic      clk,
	mem_bus_if.memory bus
);

	// word storage
	word_t mem [MEM_DEPTH];

	// access address folded onto the array depth
	mem_addr_t base_idx;

	// read word captured when the read is strobed
	word_t rdata_q;

	// delay line with one bit per cycle of wait
	logic [MEM_WAIT-1:0] ack_pipe;

	assign base_idx = bus.addr[MEM_ADDR_W-1:0];

	// ack pops out MEM_WAIT cycles after req
	assign bus.ack = ack_pipe[MEM_WAIT-1];
	// read data stays stable from the cycle after req through ack
	assign bus.rdata = rdata_q;

	// req strobe travels down the delay line
	always_ff @(posedge clk) begin
		ack_pipe <= {ack_pipe[MEM_WAIT-2:0], bus.req};
	end

	// block write of four consecutive words that wraps at the top
	always_ff @(posedge clk) begin
		if (bus.req && bus.write) begin
			for (int i = 0; i < BLOCK_WORDS; i++) begin
				mem[base_idx + mem_addr_t'(i)] <= bus.wdata[i];
			end
		end
	end

	// single word read
	always_ff @(posedge clk) begin
		if (bus.req && !bus.write)
			rdata_q <= mem[base_idx];
	end

endmodule

// ==== source/bus_arbiter.sv ====
module bus_arbiter import dma_pkg::*; (
	input  logic           clk,
	input  logic           rst,
	// DMA ownership handshake
	input  logic           bus_request,
	output logic           bus_grant,
	// CPU single-word read port
	input  logic           cpu_rd_strobe,
	input  word_t          cpu_rd_addr,
	output logic           cpu_rd_done,
	output word_t          cpu_rd_data,
	// DMA accesses come in here
	mem_bus_if.arbiter     dma_side,
	// and leave towards the memory here
	mem_bus_if.arbiter_out mem_side
);

	arb_owner_t owner;

	// one held CPU read
	logic pend_valid;
	word_t pend_addr;
	// registered strobe that issues the CPU read
	logic cpu_req;
	// a new read is accepted only when none is held
	logic cpu_take;

	assign cpu_take = cpu_rd_strobe && !pend_valid;

	assign bus_grant = (owner == ARB_DMA);

	// memory side follows the owner, DMA accesses pass straight through
	assign mem_side.req = cpu_req || ((owner == ARB_DMA) && dma_side.req);
	assign mem_side.write = (owner == ARB_DMA) && dma_side.write;
	assign mem_side.addr = (owner == ARB_CPU) ? pend_addr : dma_side.addr;
	assign mem_side.wdata = dma_side.wdata;

	// acknowledge goes back only to whoever owns the bus
	assign dma_side.ack = (owner == ARB_DMA) && mem_side.ack;
	assign dma_side.rdata = mem_side.rdata;
	assign cpu_rd_done = (owner == ARB_CPU) && mem_side.ack;
	assign cpu_rd_data = mem_side.rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			owner <= ARB_IDLE;
			pend_valid <= 1'b0;
			cpu_req <= 1'b0;
		end else begin
			cpu_req <= 1'b0;
			if (cpu_take)
				pend_valid <= 1'b1;
			case (owner)
				ARB_IDLE: begin
					// a held or fresh CPU read wins over the DMA
					if (pend_valid || cpu_take) begin
						owner <= ARB_CPU;
						cpu_req <= 1'b1;
					end else if (bus_request) begin
						owner <= ARB_DMA;
					end
				end
				ARB_CPU: begin
					if (mem_side.ack) begin
						owner <= ARB_IDLE;
						pend_valid <= 1'b0;
					end
				end
				ARB_DMA: begin
					// grant falls the cycle after request falls
					if (!bus_request)
						owner <= ARB_IDLE;
				end
				default: owner <= ARB_IDLE;
			endcase
		end
	end

	// read address is held until the read is issued
	always_ff @(posedge clk) begin
		if (cpu_take)
			pend_addr <= cpu_rd_addr;
	end

endmodule

// ==== source/dma_controller.sv ====
module dma_controller import dma_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	// command from the CPU
	input  logic       cmd_valid,
	input  word_t      cmd_address,
	input  word_t      cmd_length,
	// bus ownership handshake with the arbiter
	output logic       bus_request,
	input  logic       bus_grant,
	// external device
	output logic       dev_valid,
	output word_t      dev_offset,
	input  block_t     dev_data,
	// end of transfer
	output logic       interrupt,
	// memory writes go out through the arbiter
	mem_bus_if.master  bus
);

	dma_state_t state;

	// blocks still to move are counted against this
	word_t block_count;
	// current block index, also shown to the device
	word_t offset;
	// start address latched from the command
	word_t base_addr;
	// write address and block for the pending memory write
	word_t wr_addr;
	block_t wr_data;

	// length in words to whole blocks, the remainder is dropped
	word_t cmd_blocks;
	logic last_block;

	assign cmd_blocks = cmd_length >> BLOCK_SHIFT;
	assign last_block = (offset == block_count - word_t'(1));

	// bus is wanted from the cycle after acceptance until the last ack
	assign bus_request = (state == DMA_REQUEST) || (state == DMA_FETCH) ||
		(state == DMA_WRITE) || (state == DMA_WAIT_ACK);

	// device strobe lasts exactly the one FETCH cycle
	assign dev_valid = (state == DMA_FETCH);
	assign dev_offset = offset;

	// the engine only ever writes
	assign bus.req = (state == DMA_WRITE);
	assign bus.write = 1'b1;
	assign bus.addr = wr_addr;
	assign bus.wdata = wr_data;

	// control path
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= DMA_IDLE;
			block_count <= '0;
			offset <= '0;
			interrupt <= 1'b0;
		end else begin
			// interrupt is a single-cycle pulse
			interrupt <= 1'b0;
			case (state)
				DMA_IDLE: begin
					// commands are only taken here, anything else is dropped
					if (cmd_valid) begin
						block_count <= cmd_blocks;
						offset <= '0;
						// nothing to move, go straight to the interrupt
						if (cmd_blocks == '0)
							state <= DMA_RELEASE;
						else
							state <= DMA_REQUEST;
					end
				end
				DMA_REQUEST: begin
					// first device strobe in the cycle after grant
					if (bus_grant)
						state <= DMA_FETCH;
				end
				DMA_FETCH: begin
					// device data is sampled at the end of this cycle
					state <= DMA_WRITE;
				end
				DMA_WRITE: begin
					state <= DMA_WAIT_ACK;
				end
				DMA_WAIT_ACK: begin
					if (bus.ack) begin
						if (last_block) begin
							state <= DMA_RELEASE;
						end else begin
							offset <= offset + word_t'(1);
							state <= DMA_FETCH;
						end
					end
				end
				DMA_RELEASE: begin
					// request is already low, wait for the arbiter to drop grant
					if (!bus_grant) begin
						interrupt <= 1'b1;
						state <= DMA_IDLE;
					end
				end
				default: state <= DMA_IDLE;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (state == DMA_IDLE && cmd_valid)
			base_addr <= cmd_address;
		// capture the device block and its target address together
		if (state == DMA_FETCH) begin
			wr_data <= dev_data;
			wr_addr <= base_addr + (offset << BLOCK_SHIFT);
		end
	end

endmodule

// ==== source/mem_bus_if.sv ====
interface mem_bus_if import dma_pkg::*; ();

	// one-cycle strobe from the master, never repeated before ack
	logic req;
	// 1 = block write, 0 = single word read
	logic write;
	// word address of the access
	word_t addr;
	// block payload for writes
	block_t wdata;
	// one-cycle strobe from the slave, exactly one per req
	logic ack;
	// read word, valid together with ack
	word_t rdata;

	// bus master side (DMA engine, or the arbiter towards memory)
	modport master (
		output req, write, addr, wdata,
		input  ack, rdata
	);

	// arbiter facing a master
	modport arbiter (
		input  req, write, addr, wdata,
		output ack, rdata
	);

	// arbiter driving the memory
	modport arbiter_out (
		output req, write, addr, wdata,
		input  ack, rdata
	);

	// memory slave side
	modport memory (
		input  req, write, addr, wdata,
		output ack, rdata
	);

endinterface

// ==== source/dma_pkg.sv ====
package dma_pkg;

	// data and address word width
	localparam int WORD_W = 16;

	// words moved per device block, also the address stride per offset
	localparam int BLOCK_WORDS = 4;

	// shift that turns a block index into a word offset and a length into a block count
	localparam int BLOCK_SHIFT = $clog2(BLOCK_WORDS);

	// memory size in words, addresses wrap at this depth
	localparam int MEM_DEPTH = 256;

	// index width into the memory array
	localparam int MEM_ADDR_W = $clog2(MEM_DEPTH);

	// cycles from a memory req strobe to its ack
	localparam int MEM_WAIT = 2;

	// one bus word, used for addresses, lengths, offsets and read data
	typedef logic [WORD_W-1:0] word_t;

	// four packed words, word 0 in the low bits goes to the lowest address
	typedef logic [BLOCK_WORDS-1:0][WORD_W-1:0] block_t;

	// word index inside the memory array
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	// transfer engine states
	typedef enum logic [2:0] {
		DMA_IDLE,
		DMA_REQUEST,
		DMA_FETCH,
		DMA_WRITE,
		DMA_WAIT_ACK,
		DMA_RELEASE
	} dma_state_t;

	// current owner of the shared memory bus
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_CPU,
		ARB_DMA
	} arb_owner_t;

endpackage
